// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_datapath
FILELIST  ?= sim.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== sim.f ====
verilog/cpu_types_pkg.sv
verilog/datapath_types_pkg.sv
verilog/forwarding_unit.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/datapath.sv
verification/datapath_assertions.sv
verification/tb_datapath.sv

// ==== verification/datapath_assertions.sv ====
// concurrent protocol checks on the datapath top level, bound into every instance
module datapath_assertions (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 dhit,
  input logic                 dmemREN,
  input logic                 dmemWEN,
  input logic                 halt,
  input cpu_types_pkg::word_t dmemaddr,
  input cpu_types_pkg::word_t dmemstore
);

  // once raised, halt holds until the next reset
  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt dropped without reset");

  // one data access at a time
  strobes_exclusive: assert property (@(posedge CLK) !(dmemREN && dmemWEN))
    else $error("dmemREN and dmemWEN high together");

  // a waiting request keeps address and store data
  request_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemREN || dmemWEN) && !dhit |=> $stable(dmemaddr) && $stable(dmemstore))
    else $error("data request changed before dhit");

  // no data access while held in reset
  quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !dmemREN && !dmemWEN)
    else $error("data strobe high during reset");

endmodule

bind datapath datapath_assertions CHK (.*);

// ==== verification/datapath_cases.txt ====
# T name rerun_with_waits | P program word (from address 0) | D addr word preset
# S addr data expected store, in order; text after the numbers is ignored
T arith 1
P 24010005 addiu r1,r0,5
P 2402fffd addiu r2,r0,-3
P 00221821 addu r3,r1,r2
P 00612023 subu r4,r3,r1
P ac030000 sw r3,0
P ac040004 sw r4,4
P 0081282a slt r5,r4,r1
P 00013100 sll r6,r1,4
P 3c071234 lui r7,0x1234
P 34e75678 ori r7,r7,0x5678
P 30e8ff0f andi r8,r7,0xff0f
P 00e84826 xor r9,r7,r8
P 00210021 addu r0,r1,r1
P 00055021 addu r10,r0,r5
P ac050008 sw r5,8
P ac06000c sw r6,12
P ac090010 sw r9,16
P ac0a0014 sw r10,20
P ac080018 sw r8,24
P fc000000 halt
S 00000000 00000002
S 00000004 fffffffd
S 00000008 00000001
S 0000000c 00000050
S 00000010 12340070
S 00000014 00000001
S 00000018 00005608
T loadstore 1
P 8c010100 lw r1,0x100
P 8c020104 lw r2,0x104
P 00000000 nop
P ac010200 sw r1,0x200
P 00221821 addu r3,r1,r2
P ac030104 sw r3,0x104
P 8c040104 lw r4,0x104
P 00000000 nop
P ac040204 sw r4,0x204
P fc000000 halt
D 00000100 cafef00d
D 00000104 00000011
S 00000200 cafef00d
S 00000104 cafef01e
S 00000204 cafef01e
T branch 1
P 24010007 addiu r1,r0,7
P 24020007 addiu r2,r0,7
P 10220002 beq r1,r2,+2 taken
P ac010300 sw squashed
P ac010304 sw squashed
P 14220002 bne r1,r2,+2 not taken
P ac010308 sw r1,0x308
P 0c00000b jal 0x2c
P ac01030c sw squashed
P ac010310 sw squashed
P fc000000 halt skipped by jal
P ac1f0314 sw r31,0x314
P 0800000e j 0x38
P ac010318 sw squashed
P 14200001 bne r1,r0,+1 taken
P ac01031c sw squashed
P fc000000 halt
P ac010320 sw after halt
P ac020324 sw after halt
S 00000308 00000007
S 00000314 00000020

// ==== verification/tb_datapath.sv ====
// pipelined datapath testbench with memory models, wait states, case reader and store checks
module tb_datapath;
  import cpu_types_pkg::*;

  logic  CLK;
  logic  nRST;
  logic  ihit;
  logic  dhit;
  word_t imemload;
  word_t dmemload;
  word_t imemaddr;
  word_t dmemaddr;
  word_t dmemstore;
  logic  dmemREN;
  logic  dmemWEN;
  logic  halt;

  // word-addressed memories of 1 KiB each
  word_t imem [256];
  word_t dmem [256];

  // parsed cases kept in flat queues indexed by per-case offsets
  string names [$];
  bit    waits [$];
  int    pstart [$];
  int    pcount [$];
  int    dstart [$];
  int    dcount [$];
  int    sstart [$];
  int    scount [$];
  word_t prog_q [$];
  word_t dat_a [$];
  word_t dat_d [$];
  word_t exp_a [$];
  word_t exp_d [$];

  // stores seen at the ports in the current run
  word_t log_a [$];
  word_t log_d [$];

  logic [31:0] lfsr;
  bit          use_waits;
  int          errors;
  int          run_errors;
  int          runs;
  int          runs_failed;
  int          limit_cycles;
  string       cur_name;

  datapath UUT (.*);

  always #5 CLK = ~CLK;

  assign imemload = imem[imemaddr[9:2]];
  // read data only shows up for a read that completes this cycle
  assign dmemload = (dmemREN && dhit) ? dmem[dmemaddr[9:2]] : 32'hbad0_0bad;

  // galois lfsr with taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr bit per hit signal per cycle
  always @(posedge CLK)
  begin
    if (use_waits)
    begin
      ihit <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      dhit <= lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    else
    begin
      ihit <= 1'b1;
      dhit <= 1'b1;
    end
  end

  // a store completes in the cycle dhit is high
  always @(posedge CLK)
  begin
    if (nRST && dmemWEN && dhit)
    begin
      log_a.push_back(dmemaddr);
      log_d.push_back(dmemstore);
      dmem[dmemaddr[9:2]] = dmemstore;
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  // each line holds a tag T, P, D or S followed by its fields
  task automatic read_cases();
    int    fd;
    int    n;
    string line;
    string tag;
    string nm;
    int    w;
    word_t a;
    word_t d;
    fd = $fopen("verification/datapath_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the cases file");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != 8'h23)
        begin
          n = $sscanf(line, "%s", tag);
          if (tag == "T")
          begin
            n = $sscanf(line, "%s %s %d", tag, nm, w);
            names.push_back(nm);
            waits.push_back(w != 0);
            pstart.push_back(prog_q.size());
            dstart.push_back(dat_a.size());
            sstart.push_back(exp_a.size());
            pcount.push_back(0);
            dcount.push_back(0);
            scount.push_back(0);
          end
          else if (tag == "P")
          begin
            n = $sscanf(line, "%s %h", tag, d);
            prog_q.push_back(d);
            pcount[pcount.size()-1]++;
          end
          else if (tag == "D" || tag == "S")
          begin
            n = $sscanf(line, "%s %h %h", tag, a, d);
            if (tag == "D")
            begin
              dat_a.push_back(a);
              dat_d.push_back(d);
              dcount[dcount.size()-1]++;
            end
            else
            begin
              exp_a.push_back(a);
              exp_d.push_back(d);
              scount[scount.size()-1]++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int c, input bit ws);
    @(posedge CLK);
    nRST <= 1'b0;
    use_waits <= ws;
    cur_name = ws ? {names[c], "_wait"} : names[c];
    run_errors = errors;
    // unused program slots decode as nop
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = '0;
      dmem[i] = ~(word_t'(i) << 2) ^ 32'h5a5a_0000;
    end
    for (int i = 0; i < pcount[c]; i++)
      imem[i] = prog_q[pstart[c] + i];
    for (int i = 0; i < dcount[c]; i++)
      dmem[dat_a[dstart[c] + i][9:2]] = dat_d[dstart[c] + i];
    log_a.delete();
    log_d.delete();
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    while (!halt)
      @(posedge CLK);
    repeat (3) @(posedge CLK);
    check_flag(halt, 1'b1, "halt held");
    check_flag(dmemWEN, 1'b0, "no store after halt");
    if (log_a.size() != scount[c])
    begin
      $display("test %s saw %0d stores where %0d were expected", cur_name, log_a.size(),
               scount[c]);
      errors++;
    end
    for (int i = 0; i < scount[c] && i < log_a.size(); i++)
    begin
      check_word(log_a[i], exp_a[sstart[c] + i], $sformatf("%s store %0d addr", cur_name, i));
      check_word(log_d[i], exp_d[sstart[c] + i], $sformatf("%s store %0d data", cur_name, i));
    end
    runs++;
    if (errors == run_errors)
      $display("test %s: ok", cur_name);
    else
    begin
      runs_failed++;
      $display("test %s: FAILED with %0d errors", cur_name, errors - run_errors);
    end
  endtask

  // run limit grows with the number of program words executed
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("timeout: halt never raised in test %s", cur_name);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    int total;
    CLK = 1'b0;
    nRST = 1'b0;
    ihit = 1'b0;
    dhit = 1'b0;
    use_waits = 1'b0;
    lfsr = 32'hd327;
    errors = 0;
    runs = 0;
    runs_failed = 0;
    limit_cycles = 0;
    cur_name = "setup";
    read_cases();
    total = 0;
    for (int c = 0; c < names.size(); c++)
      total += pcount[c] * (waits[c] ? 2 : 1);
    limit_cycles = 200 * total + 20;
    // flagged cases run again with random wait states
    for (int c = 0; c < names.size(); c++)
    begin
      run_case(c, 1'b0);
      if (waits[c])
        run_case(c, 1'b1);
    end
    $display("summary: %0d runs, %0d passed, %0d failed", runs, runs - runs_failed,
             runs_failed);
    if (errors == 0 && runs > 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== verilog/cpu_types_pkg.sv ====
// isa field widths, word and register index types, opcode and funct encodings
package cpu_types_pkg;

  // instruction field widths
  localparam int OP_W   = 6;
  localparam int REG_W  = 5;
  localparam int IMM_W  = 16;
  localparam int ADDR_W = 26;

  typedef logic [31:0] word_t;
  typedef logic [REG_W-1:0] regbits_t;

  // primary opcode, instr[31:26]
  typedef enum logic [OP_W-1:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2a
  } funct_t;

endpackage

// ==== verilog/datapath.sv ====
// pipeline top level with memory stage strobes, MEM/WB register, writeback and halt
module datapath (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t imemload,
  input  cpu_types_pkg::word_t dmemload,
  output cpu_types_pkg::word_t imemaddr,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output logic                 halt
);
  import cpu_types_pkg::*;
  import datapath_types_pkg::*;

  logic     mem_wait;
  logic     redirect;
  word_t    redirect_pc;
  logic     fd_valid;
  word_t    fd_pc;
  word_t    fd_instr;
  logic     de_valid;
  logic     de_regwr;
  logic     de_memrd;
  logic     de_memwr;
  logic     de_memtoreg;
  logic     de_alusrc;
  logic     de_branch;
  logic     de_bne;
  logic     de_jump;
  logic     de_link;
  logic     de_halt;
  aluop_t   de_aluop;
  regbits_t de_rs;
  regbits_t de_rt;
  regbits_t de_wsel;
  word_t    de_rdat1;
  word_t    de_rdat2;
  word_t    de_imm;
  word_t    de_pc;
  word_t    de_jaddr;
  word_t    opa;
  word_t    opb;
  logic     em_valid;
  logic     em_regwr;
  logic     em_memrd;
  logic     em_memwr;
  logic     em_memtoreg;
  logic     em_halt;
  regbits_t em_wsel;
  word_t    em_result;
  word_t    em_store;
  logic     mw_valid;
  logic     mw_regwr;
  logic     mw_memtoreg;
  logic     mw_halt;
  regbits_t mw_wsel;
  word_t    mw_result;
  word_t    mw_load;
  logic     wb_en;
  word_t    wb_data;

  fetch_stage FSTAGE (
    .CLK, .nRST, .ihit, .stall(mem_wait), .redirect, .imemload, .redirect_pc,
    .imemaddr, .fd_pc, .fd_instr, .fd_valid
  );

  decode_stage DSTAGE (
    .CLK, .nRST, .stall(mem_wait), .redirect, .fd_valid, .wb_en, .fd_pc, .fd_instr,
    .wb_data, .wb_sel(mw_wsel), .de_valid, .de_regwr, .de_memrd, .de_memwr,
    .de_memtoreg, .de_alusrc, .de_branch, .de_bne, .de_jump, .de_link, .de_halt,
    .de_aluop, .de_rs, .de_rt, .de_wsel, .de_rdat1, .de_rdat2, .de_imm, .de_pc,
    .de_jaddr
  );

  // only live entries may feed the bypass
  forwarding_unit FWD (
    .rs(de_rs), .rt(de_rt), .em_wsel, .mw_wsel, .em_regwr(em_valid & em_regwr),
    .mw_regwr(wb_en), .rdat1(de_rdat1), .rdat2(de_rdat2), .em_result,
    .mw_result(wb_data), .opa, .opb
  );

  exec_stage ESTAGE (
    .CLK, .nRST, .stall(mem_wait), .de_valid, .de_regwr, .de_memrd, .de_memwr,
    .de_memtoreg, .de_alusrc, .de_branch, .de_bne, .de_jump, .de_link, .de_halt,
    .de_aluop, .de_wsel, .de_imm, .de_pc, .de_jaddr, .opa, .opb, .redirect,
    .redirect_pc, .em_valid, .em_regwr, .em_memrd, .em_memwr, .em_memtoreg,
    .em_halt, .em_wsel, .em_result, .em_store
  );

  // memory stage, request held until dhit
  assign dmemREN   = em_valid & em_memrd;
  assign dmemWEN   = em_valid & em_memwr;
  assign dmemaddr  = em_result;
  assign dmemstore = em_store;
  assign mem_wait  = (dmemREN | dmemWEN) & ~dhit;

  // MEM/WB keeps its entry while the dcache is busy so bypass data stays put
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      mw_valid    <= 1'b0;
      mw_regwr    <= 1'b0;
      mw_memtoreg <= 1'b0;
      mw_halt     <= 1'b0;
    end
    else if (!mem_wait)
    begin
      mw_valid    <= em_valid;
      mw_regwr    <= em_regwr;
      mw_memtoreg <= em_memtoreg;
      mw_halt     <= em_halt;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!mem_wait)
    begin
      mw_wsel   <= em_wsel;
      mw_result <= em_result;
      mw_load   <= dmemload;
    end
  end

  // writeback select
  assign wb_en   = mw_valid & mw_regwr;
  assign wb_data = mw_memtoreg ? mw_load : mw_result;

  // halt latches one edge after HALT reaches MEM/WB
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt <= 1'b0;
    else if (mw_valid && mw_halt)
      halt <= 1'b1;
  end

endmodule

// ==== verilog/datapath_types_pkg.sv ====
// alu operation encoding, reset pc and link register index
package datapath_types_pkg;

  // alu operations selected in decode
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_SLL = 3'd6,
    ALU_LUI = 3'd7
  } aluop_t;

  // first fetch address out of reset
  localparam cpu_types_pkg::word_t PC_INIT = 32'h0000_0000;

  // jal writes its return address here
  localparam cpu_types_pkg::regbits_t LINK_REG = 5'd31;

endpackage

// ==== verilog/decode_stage.sv ====
// control decode, register file with write through, halt squash and ID/EX register
module decode_stage (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          stall,
  input  logic                          redirect,
  input  logic                          fd_valid,
  input  logic                          wb_en,
  input  cpu_types_pkg::word_t          fd_pc,
  input  cpu_types_pkg::word_t          fd_instr,
  input  cpu_types_pkg::word_t          wb_data,
  input  cpu_types_pkg::regbits_t       wb_sel,
  output logic                          de_valid,
  output logic                          de_regwr,
  output logic                          de_memrd,
  output logic                          de_memwr,
  output logic                          de_memtoreg,
  output logic                          de_alusrc,
  output logic                          de_branch,
  output logic                          de_bne,
  output logic                          de_jump,
  output logic                          de_link,
  output logic                          de_halt,
  output datapath_types_pkg::aluop_t    de_aluop,
  output cpu_types_pkg::regbits_t       de_rs,
  output cpu_types_pkg::regbits_t       de_rt,
  output cpu_types_pkg::regbits_t       de_wsel,
  output cpu_types_pkg::word_t          de_rdat1,
  output cpu_types_pkg::word_t          de_rdat2,
  output cpu_types_pkg::word_t          de_imm,
  output cpu_types_pkg::word_t          de_pc,
  output cpu_types_pkg::word_t          de_jaddr
);
  import cpu_types_pkg::*;
  import datapath_types_pkg::*;

  word_t    regs [32];
  opcode_t  op;
  funct_t   fn;
  regbits_t rs;
  regbits_t rt;
  regbits_t rd;
  word_t    imm;
  word_t    rdat1;
  word_t    rdat2;
  word_t    pc_plus4;
  logic     regwr;
  logic     memrd;
  logic     memwr;
  logic     alusrc;
  logic     zext;
  logic     rtype;
  aluop_t   aluop;
  logic     halt_seen;

  assign op       = opcode_t'(fd_instr[31:26]);
  assign fn       = funct_t'(fd_instr[5:0]);
  assign rs       = fd_instr[25:21];
  assign rt       = fd_instr[20:16];
  assign rd       = fd_instr[15:11];
  assign pc_plus4 = fd_pc + 32'd4;

  always_comb
  begin
    regwr  = 1'b0;
    memrd  = 1'b0;
    memwr  = 1'b0;
    alusrc = 1'b1;
    zext   = 1'b0;
    rtype  = 1'b0;
    aluop  = ALU_ADD;
    case (op)
      RTYPE:
      begin
        rtype  = 1'b1;
        alusrc = 1'b0;
        regwr  = 1'b1;
        case (fn)
          SLL:     aluop = ALU_SLL;
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          XOR:     aluop = ALU_XOR;
          SLT:     aluop = ALU_SLT;
          default: regwr = 1'b0;
        endcase
      end
      ADDIU:   regwr = 1'b1;
      ANDI:
      begin
        regwr = 1'b1;
        zext  = 1'b1;
        aluop = ALU_AND;
      end
      ORI:
      begin
        regwr = 1'b1;
        zext  = 1'b1;
        aluop = ALU_OR;
      end
      LUI:
      begin
        regwr = 1'b1;
        zext  = 1'b1;
        aluop = ALU_LUI;
      end
      LW:
      begin
        regwr = 1'b1;
        memrd = 1'b1;
      end
      SW:      memwr  = 1'b1;
      // compare rs against rt, not the immediate
      BEQ:     alusrc = 1'b0;
      BNE:     alusrc = 1'b0;
      default: alusrc = 1'b1;
    endcase
  end

  // shamt rides in the immediate slot for r-type
  always_comb
  begin
    if (rtype)
      imm = word_t'(fd_instr[10:6]);
    else if (zext)
      imm = word_t'(fd_instr[IMM_W-1:0]);
    else
      imm = {{(32-IMM_W){fd_instr[IMM_W-1]}}, fd_instr[IMM_W-1:0]};
  end

  // register file reads, r0 hardwired, writeback forwarded same cycle
  always_comb
  begin
    rdat1 = regs[rs];
    rdat2 = regs[rt];
    if (wb_en && wb_sel == rs)
      rdat1 = wb_data;
    if (wb_en && wb_sel == rt)
      rdat2 = wb_data;
    if (rs == '0)
      rdat1 = '0;
    if (rt == '0)
      rdat2 = '0;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      regs <= '{default: '0};
    else if (wb_en && wb_sel != '0)
      regs[wb_sel] <= wb_data;
  end

  // once halt is accepted nothing younger enters execute
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      halt_seen <= 1'b0;
    else if (!stall && !redirect && fd_valid && op == HALT)
      halt_seen <= 1'b1;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      de_valid    <= 1'b0;
      de_regwr    <= 1'b0;
      de_memrd    <= 1'b0;
      de_memwr    <= 1'b0;
      de_memtoreg <= 1'b0;
      de_alusrc   <= 1'b0;
      de_branch   <= 1'b0;
      de_bne      <= 1'b0;
      de_jump     <= 1'b0;
      de_link     <= 1'b0;
      de_halt     <= 1'b0;
      de_aluop    <= ALU_ADD;
    end
    else if (!stall)
    begin
      de_valid    <= fd_valid & ~redirect & ~halt_seen;
      de_regwr    <= regwr | (op == JAL);
      de_memrd    <= memrd;
      de_memwr    <= memwr;
      de_memtoreg <= memrd;
      de_alusrc   <= alusrc;
      de_branch   <= (op == BEQ) | (op == BNE);
      de_bne      <= (op == BNE);
      de_jump     <= (op == J) | (op == JAL);
      de_link     <= (op == JAL);
      de_halt     <= (op == HALT);
      de_aluop    <= aluop;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!stall)
    begin
      de_rs    <= rs;
      de_rt    <= rt;
      de_wsel  <= rtype ? rd : rt;
      de_rdat1 <= rdat1;
      de_rdat2 <= rdat2;
      de_imm   <= imm;
      de_pc    <= fd_pc;
      // region of pc+4 joined with the word index
      de_jaddr <= {pc_plus4[31:28], fd_instr[ADDR_W-1:0], 2'b00};
    end
  end

endmodule

// ==== verilog/exec_stage.sv ====
// alu, branch and jump resolution, and the EX/MEM register
module exec_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       stall,
  input  logic                       de_valid,
  input  logic                       de_regwr,
  input  logic                       de_memrd,
  input  logic                       de_memwr,
  input  logic                       de_memtoreg,
  input  logic                       de_alusrc,
  input  logic                       de_branch,
  input  logic                       de_bne,
  input  logic                       de_jump,
  input  logic                       de_link,
  input  logic                       de_halt,
  input  datapath_types_pkg::aluop_t de_aluop,
  input  cpu_types_pkg::regbits_t    de_wsel,
  input  cpu_types_pkg::word_t       de_imm,
  input  cpu_types_pkg::word_t       de_pc,
  input  cpu_types_pkg::word_t       de_jaddr,
  input  cpu_types_pkg::word_t       opa,
  input  cpu_types_pkg::word_t       opb,
  output logic                       redirect,
  output cpu_types_pkg::word_t       redirect_pc,
  output logic                       em_valid,
  output logic                       em_regwr,
  output logic                       em_memrd,
  output logic                       em_memwr,
  output logic                       em_memtoreg,
  output logic                       em_halt,
  output cpu_types_pkg::regbits_t    em_wsel,
  output cpu_types_pkg::word_t       em_result,
  output cpu_types_pkg::word_t       em_store
);
  import cpu_types_pkg::*;
  import datapath_types_pkg::*;

  word_t alu_b;
  word_t alu_out;
  word_t pc_plus4;
  logic  taken;

  assign alu_b    = de_alusrc ? de_imm : opb;
  assign pc_plus4 = de_pc + 32'd4;

  always_comb
  begin
    case (de_aluop)
      ALU_ADD: alu_out = opa + alu_b;
      ALU_SUB: alu_out = opa - alu_b;
      ALU_AND: alu_out = opa & alu_b;
      ALU_OR:  alu_out = opa | alu_b;
      ALU_XOR: alu_out = opa ^ alu_b;
      ALU_SLT: alu_out = word_t'($signed(opa) < $signed(alu_b));
      // shift amount comes from the immediate slot
      ALU_SLL: alu_out = alu_b << de_imm[4:0];
      ALU_LUI: alu_out = {alu_b[IMM_W-1:0], {IMM_W{1'b0}}};
      default: alu_out = opa + alu_b;
    endcase
  end

  // beq takes on equal, bne on not equal
  assign taken       = de_jump | (de_branch & ((opa == opb) ^ de_bne));
  assign redirect    = de_valid & taken;
  assign redirect_pc = de_jump ? de_jaddr : pc_plus4 + {de_imm[29:0], 2'b00};

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      em_valid    <= 1'b0;
      em_regwr    <= 1'b0;
      em_memrd    <= 1'b0;
      em_memwr    <= 1'b0;
      em_memtoreg <= 1'b0;
      em_halt     <= 1'b0;
    end
    else if (!stall)
    begin
      em_valid    <= de_valid;
      em_regwr    <= de_regwr;
      em_memrd    <= de_memrd;
      em_memwr    <= de_memwr;
      em_memtoreg <= de_memtoreg;
      em_halt     <= de_halt;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!stall)
    begin
      em_wsel   <= de_link ? LINK_REG : de_wsel;
      // jal writes its return address
      em_result <= de_link ? pc_plus4 : alu_out;
      em_store  <= opb;
    end
  end

endmodule

// ==== verilog/fetch_stage.sv ====
// program counter, next pc selection and the IF/ID pipeline register
module fetch_stage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 stall,
  input  logic                 redirect,
  input  cpu_types_pkg::word_t imemload,
  input  cpu_types_pkg::word_t redirect_pc,
  output cpu_types_pkg::word_t imemaddr,
  output cpu_types_pkg::word_t fd_pc,
  output cpu_types_pkg::word_t fd_instr,
  output logic                 fd_valid
);
  import cpu_types_pkg::*;
  import datapath_types_pkg::*;

  word_t pc;
  word_t pc_next;

  assign imemaddr = pc;

  // data stall freezes pc, taken branch wins over sequential fetch
  always_comb
  begin
    pc_next = pc;
    if (stall)
      pc_next = pc;
    else if (redirect)
      pc_next = redirect_pc;
    else if (ihit)
      pc_next = pc + 32'd4;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc       <= PC_INIT;
      fd_valid <= 1'b0;
    end
    else
    begin
      pc <= pc_next;
      // bubble on icache miss or on a squashed slot
      if (!stall)
        fd_valid <= ihit & ~redirect;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!stall)
    begin
      fd_pc    <= pc;
      fd_instr <= imemload;
    end
  end

endmodule

// ==== verilog/forwarding_unit.sv ====
// operand bypass from EX/MEM and MEM/WB into execute
module forwarding_unit (
  input  cpu_types_pkg::regbits_t rs,
  input  cpu_types_pkg::regbits_t rt,
  input  cpu_types_pkg::regbits_t em_wsel,
  input  cpu_types_pkg::regbits_t mw_wsel,
  input  logic                    em_regwr,
  input  logic                    mw_regwr,
  input  cpu_types_pkg::word_t    rdat1,
  input  cpu_types_pkg::word_t    rdat2,
  input  cpu_types_pkg::word_t    em_result,
  input  cpu_types_pkg::word_t    mw_result,
  output cpu_types_pkg::word_t    opa,
  output cpu_types_pkg::word_t    opb
);

  logic em_ok;
  logic mw_ok;

  // r0 writes never forward
  assign em_ok = em_regwr && em_wsel != '0;
  assign mw_ok = mw_regwr && mw_wsel != '0;

  // youngest producer first
  always_comb
  begin
    opa = rdat1;
    if (em_ok && em_wsel == rs)
      opa = em_result;
    else if (mw_ok && mw_wsel == rs)
      opa = mw_result;

    opb = rdat2;
    if (em_ok && em_wsel == rt)
      opb = em_result;
    else if (mw_ok && mw_wsel == rt)
      opb = mw_result;
  end

endmodule
